// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_top
FILELIST  = files.f

SRCS = $(shell grep -v '^+' $(FILELIST)) verilog/twi_defs.svh
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) verif/twi_stim.txt
	./$(BIN) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== files.f ====
+incdir+verilog
verilog/twi_pkg.sv
verilog/twi_regs.sv
verilog/twi_bit_rate.sv
verilog/twi_master.sv
verilog/twi_top.sv
verif/tb_monitor.sv
verif/tb_top.sv

// ==== verif/tb_monitor.sv ====
/*
 * Checker for the TWI master. Decodes START, bytes and STOP on the bus,
 * times SCL high phases and compares register reads and the interrupt.
 */
`timescale 1ns/10ps

module tb_monitor import twi_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  twi_pins_t   pins,
    input  logic        sda_in,
    input  logic [7:0]  io_rdata,
    input  logic        twi_interrupt,
    input  logic        chk_en,
    input  logic [3:0]  chk_id,
    input  logic [7:0]  chk_exp,
    input  int          line_no,
    input  logic [7:0]  exp_addr,
    input  logic [7:0]  exp_data,
    input  logic        exp_aack,
    input  logic        exp_dack,
    input  logic [16:0] exp_high,
    output int          errors
);

    logic       scl;
    logic       scl_q;
    logic       sda_q;
    logic       busy;       // Between START and STOP
    int         nbits;
    int         nbytes;
    int         high_cnt;
    logic [8:0] sh;

    assign scl = ~pins.scl_drive_low;

    function automatic string check_name(input logic [3:0] id);
        case (id)
            4'd1:    return "RESET_TWSR";
            4'd2:    return "RESET_TWCR";
            4'd3:    return "RESET_TWBR";
            4'd4:    return "PRESCALER_WRITE";
            4'd5:    return "START_STATUS";
            4'd6:    return "ADDR_STATUS";
            4'd7:    return "DATA_STATUS";
            4'd8:    return "STOP_TWCR";
            4'd9:    return "STOP_STATUS";
            4'd10:   return "INT_SET";
            4'd11:   return "INT_CLEAR";
            default: return "RESET_INT";
        endcase
    endfunction

    task automatic mismatch(input string name, input int exp, input int act);
        $display("MISMATCH line %0d %s: expected %0h, actual %0h", line_no, name, exp, act);
        errors = errors + 1;
    endtask

    always @(posedge clk) begin
        logic [7:0] act;
        if (!reset_n) begin
            scl_q    = 1'b1;
            sda_q    = 1'b1;
            busy     = 1'b0;
            nbits    = 0;
            nbytes   = 0;
            high_cnt = 0;
            errors   = 0;
        end else begin
            if (chk_en) begin
                act = (chk_id >= 4'd10) ? {7'b0, twi_interrupt} : io_rdata;
                if (act !== chk_exp)
                    mismatch(check_name(chk_id), chk_exp, act);
            end

            if (scl && scl_q && sda_q && !sda_in) begin
                if (busy) begin
                    $display("Line %0d: START seen inside a transaction", line_no);
                    errors = errors + 1;
                end
                busy   = 1'b1;
                nbits  = 0;
                nbytes = 0;
            end else if (scl && scl_q && !sda_q && sda_in) begin
                // The SCL rise of the STOP itself counts as one bit
                if (!busy || nbytes != 2 || nbits != 1) begin
                    $display("Line %0d: STOP after %0d bytes and %0d bits",
                             line_no, nbytes, nbits);
                    errors = errors + 1;
                end
                busy = 1'b0;
            end else if (!busy && scl_q && !scl) begin
                $display("Line %0d: SCL pulled low while the bus is idle", line_no);
                errors = errors + 1;
            end else if (busy && scl && !scl_q) begin
                sh    = {sh[7:0], sda_in};  // MSB first, sampled with SCL high
                nbits = nbits + 1;
            end else if (busy && !scl && scl_q && nbits > 0) begin
                if (high_cnt != int'(exp_high))
                    mismatch("SCL_HIGH", exp_high, high_cnt);
                if (nbits == 9) begin
                    if (nbytes == 0) begin
                        if (sh[8:1] !== exp_addr)
                            mismatch("ADDR_BYTE", exp_addr, sh[8:1]);
                        if (sh[0] !== ~exp_aack)
                            mismatch("ADDR_ACK", ~exp_aack, sh[0]);
                    end else if (nbytes == 1) begin
                        if (sh[8:1] !== exp_data)
                            mismatch("DATA_BYTE", exp_data, sh[8:1]);
                        if (sh[0] !== ~exp_dack)
                            mismatch("DATA_ACK", ~exp_dack, sh[0]);
                    end else begin
                        $display("Line %0d: more than two bytes on the bus", line_no);
                        errors = errors + 1;
                    end
                    nbytes = nbytes + 1;
                    nbits  = 0;
                end
            end

            if (scl)
                high_cnt = scl_q ? high_cnt + 1 : 1;
            scl_q = scl;
            sda_q = sda_in;
        end
    end

endmodule

// ==== verif/tb_top.sv ====
/*
 * Testbench top for the TWI master. Clock, reset, stim file reader,
 * CPU register driver, open-drain bus with an ACK slave, and watchdog.
 */
`timescale 1ns/10ps
`include "twi_defs.svh"

module tb_top import twi_pkg::*; ();

    localparam int MAX_LINES = 32;

    // TWCR command words: TWINT=7, TWSTA=5, TWSTO=4, TWEN=2, TWIE=0
    localparam logic [7:0] CR_EN    = 8'h04;
    localparam logic [7:0] CR_BYTE  = 8'h84;
    localparam logic [7:0] CR_START = 8'hA4;
    localparam logic [7:0] CR_STOP  = 8'h94;

    // Check ids, named in tb_monitor
    localparam logic [3:0] C_RST_TWSR  = 4'd1;
    localparam logic [3:0] C_RST_TWCR  = 4'd2;
    localparam logic [3:0] C_RST_TWBR  = 4'd3;
    localparam logic [3:0] C_PRESC     = 4'd4;
    localparam logic [3:0] C_ST_START  = 4'd5;
    localparam logic [3:0] C_ST_ADDR   = 4'd6;
    localparam logic [3:0] C_ST_DATA   = 4'd7;
    localparam logic [3:0] C_STOP_TWCR = 4'd8;
    localparam logic [3:0] C_ST_STOP   = 4'd9;
    localparam logic [3:0] C_INT_SET   = 4'd10;
    localparam logic [3:0] C_INT_CLR   = 4'd11;
    localparam logic [3:0] C_RST_INT   = 4'd12;

    logic                   clk;
    logic                   reset_n;
    logic [`TWI_ADDR_W-1:0] io_addr;
    twi_wdata_u             io_wdata;
    logic                   io_write;
    logic                   io_read;
    logic [`TWI_DATA_W-1:0] io_rdata;
    logic                   sda_in;
    twi_pins_t              pins;
    logic                   twi_interrupt;

    logic                   slave_low = 1'b0;   // Slave ACK pull-down
    logic                   chk_en;
    logic [3:0]             chk_id;
    logic [7:0]             chk_exp;
    int                     line_no;
    logic [7:0]             exp_addr;
    logic [7:0]             exp_data;
    logic                   exp_aack;
    logic                   exp_dack;
    logic [16:0]            exp_high;
    int                     mon_errors;
    int                     drv_errors;

    // Stim table
    logic [1:0]             st_ps   [MAX_LINES];
    logic [7:0]             st_twbr [MAX_LINES];
    logic                   st_ie   [MAX_LINES];
    logic [7:0]             st_addr [MAX_LINES];
    logic [7:0]             st_data [MAX_LINES];
    logic                   st_aack [MAX_LINES];
    logic                   st_dack [MAX_LINES];
    int                     n_lines;

    // Wired-AND bus with pull-up
    assign sda_in = ~pins.sda_drive_low & ~slave_low;

    twi_top i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .io_addr       (io_addr),
        .io_wdata      (io_wdata),
        .io_write      (io_write),
        .io_read       (io_read),
        .io_rdata      (io_rdata),
        .sda_in        (sda_in),
        .pins          (pins),
        .twi_interrupt (twi_interrupt)
    );

    tb_monitor i_mon (
        .clk           (clk),
        .reset_n       (reset_n),
        .pins          (pins),
        .sda_in        (sda_in),
        .io_rdata      (io_rdata),
        .twi_interrupt (twi_interrupt),
        .chk_en        (chk_en),
        .chk_id        (chk_id),
        .chk_exp       (chk_exp),
        .line_no       (line_no),
        .exp_addr      (exp_addr),
        .exp_data      (exp_data),
        .exp_aack      (exp_aack),
        .exp_dack      (exp_dack),
        .exp_high      (exp_high),
        .errors        (mon_errors)
    );

    always #50 clk = ~clk;

    // Slave model: pulls SDA in the ninth bit of a byte it acknowledges
    logic s_scl_q;
    logic s_sda_q;
    int   s_bits;
    int   s_byte;

    always @(negedge clk) begin
        logic scl;
        scl = ~pins.scl_drive_low;
        if (!reset_n) begin
            slave_low = 1'b0;
            s_bits    = 0;
            s_byte    = 0;
        end else if (scl && s_scl_q && s_sda_q && !sda_in) begin
            s_bits = 0;             // START
            s_byte = 0;
        end else if (scl && !s_scl_q) begin
            s_bits = s_bits + 1;
        end else if (!scl && s_scl_q) begin
            if (s_bits == 8)
                slave_low = (s_byte == 0) ? exp_aack : exp_dack;
            else if (s_bits == 9) begin
                slave_low = 1'b0;
                s_bits    = 0;
                s_byte    = s_byte + 1;
            end
        end
        s_scl_q = scl;
        s_sda_q = sda_in;
    end

    task automatic reg_write(input logic [1:0] addr, input logic [7:0] value);
        @(negedge clk);
        io_addr      = addr;
        io_wdata.raw = value;
        io_write     = 1'b1;
        @(negedge clk);
        io_write     = 1'b0;
    endtask

    task automatic check_reg(input logic [3:0] id, input logic [1:0] addr,
                             input logic [7:0] exp);
        @(negedge clk);
        io_addr = addr;
        io_read = 1'b1;
        chk_id  = id;
        chk_exp = exp;
        chk_en  = 1'b1;
        @(negedge clk);
        chk_en  = 1'b0;
        io_read = 1'b0;
    endtask

    task automatic check_irq(input logic [3:0] id, input logic exp);
        @(negedge clk);
        chk_id  = id;
        chk_exp = {7'b0, exp};
        chk_en  = 1'b1;
        @(negedge clk);
        chk_en  = 1'b0;
    endtask

    // Waits until (register & mask) == want
    task automatic poll_reg(input logic [1:0] addr, input logic [7:0] mask,
                            input logic [7:0] want);
        logic [7:0] v;
        logic       hit;
        hit = 1'b0;
        @(negedge clk);
        io_addr = addr;
        io_read = 1'b1;
        while (!hit) begin
            @(negedge clk);
            v   = io_rdata;
            hit = ((v & mask) == want);
        end
        io_read = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b, input logic ie, input logic [3:0] id,
                             input logic [7:0] exp_status);
        reg_write(`TWI_ADDR_TWDR, b);
        reg_write(`TWI_ADDR_TWCR, CR_BYTE | {7'b0, ie});
        check_irq(C_INT_CLR, 1'b0);
        poll_reg(`TWI_ADDR_TWCR, 8'h80, 8'h80);
        check_irq(C_INT_SET, ie);
        check_reg(id, `TWI_ADDR_TWSR, exp_status);
    endtask

    task automatic run_line(input int i);
        logic [7:0] ps;
        logic [7:0] ie;
        ps = {6'b0, st_ps[i]};
        ie = {7'b0, st_ie[i]};
        line_no  = i + 1;
        exp_addr = st_addr[i];
        exp_data = st_data[i];
        exp_aack = st_aack[i];
        exp_dack = st_dack[i];
        exp_high = 17'(int'(st_twbr[i]) * (4 ** int'(st_ps[i])) + 1);
        reg_write(`TWI_ADDR_TWBR, st_twbr[i]);
        reg_write(`TWI_ADDR_TWSR, ps);
        reg_write(`TWI_ADDR_TWCR, CR_EN | ie);
        reg_write(`TWI_ADDR_TWCR, CR_START | ie);
        check_irq(C_INT_CLR, 1'b0);
        poll_reg(`TWI_ADDR_TWCR, 8'h80, 8'h80);
        check_irq(C_INT_SET, st_ie[i]);
        check_reg(C_ST_START, `TWI_ADDR_TWSR, 8'h08 | ps);
        send_byte(st_addr[i], st_ie[i], C_ST_ADDR, (st_aack[i] ? 8'h18 : 8'h20) | ps);
        send_byte(st_data[i], st_ie[i], C_ST_DATA, (st_dack[i] ? 8'h28 : 8'h30) | ps);
        reg_write(`TWI_ADDR_TWCR, CR_STOP | ie);
        poll_reg(`TWI_ADDR_TWCR, 8'h10, 8'h00);
        check_reg(C_STOP_TWCR, `TWI_ADDR_TWCR, CR_EN | ie);
        check_reg(C_ST_STOP, `TWI_ADDR_TWSR, 8'hF8 | ps);
        check_irq(C_INT_CLR, 1'b0);
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        int    r;
        string text;
        int    v[7];
        n_lines = 0;
        fd = $fopen("verif/twi_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stim file verif/twi_stim.txt");
            drv_errors = drv_errors + 1;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                r = $fgets(text, fd);
                if (r > 0 && text.substr(0, 0) != "#") begin
                    n = $sscanf(text, "%h %h %h %h %h %h %h",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                    if (n == 7) begin
                        st_ps[n_lines]   = v[0][1:0];
                        st_twbr[n_lines] = v[1][7:0];
                        st_ie[n_lines]   = v[2][0];
                        st_addr[n_lines] = v[3][7:0];
                        st_data[n_lines] = v[4][7:0];
                        st_aack[n_lines] = v[5][0];
                        st_dack[n_lines] = v[6][0];
                        n_lines = n_lines + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        longint max_div;
        longint cycles;
        int     total;
        clk        = 1'b0;
        reset_n    = 1'b0;
        io_addr    = '0;
        io_wdata   = '0;
        io_write   = 1'b0;
        io_read    = 1'b0;
        chk_en     = 1'b0;
        chk_id     = '0;
        chk_exp    = '0;
        line_no    = 0;
        exp_addr   = '0;
        exp_data   = '0;
        exp_aack   = 1'b0;
        exp_dack   = 1'b0;
        exp_high   = '0;
        drv_errors = 0;
        load_stim();
        if (n_lines == 0) begin
            $display("The stim file holds no transactions");
            drv_errors = drv_errors + 1;
        end

        // Watchdog sized from the longest line
        max_div = 0;
        for (int i = 0; i < n_lines; i++)
            if (longint'(st_twbr[i]) * (4 ** int'(st_ps[i])) > max_div)
                max_div = longint'(st_twbr[i]) * (4 ** int'(st_ps[i]));
        cycles = longint'(n_lines) * 40 * (max_div + 1) * 2 + 2000;
        fork
            begin
                #(cycles * 100);
                $display("Watchdog expired after %0d cycles, the run did not finish", cycles);
                $display("TESTS FAILED");
                $finish;
            end
        join_none

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        check_reg(C_RST_TWSR, `TWI_ADDR_TWSR, 8'hF8);
        check_reg(C_RST_TWCR, `TWI_ADDR_TWCR, 8'h00);
        check_reg(C_RST_TWBR, `TWI_ADDR_TWBR, 8'h00);
        check_irq(C_RST_INT, 1'b0);
        reg_write(`TWI_ADDR_TWSR, 8'hFF);   // Status bits are read only
        check_reg(C_PRESC, `TWI_ADDR_TWSR, 8'hFB);

        for (int i = 0; i < n_lines; i++)
            run_line(i);

        repeat (20) @(negedge clk);
        total = mon_errors + drv_errors;
        $display("Errors: %0d (monitor %0d, driver %0d)", total, mon_errors, drv_errors);
        if (total == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verif/twi_stim.txt ====
# Columns (hex): prescaler TWBR TWIE address data address_ack data_ack
# ACK columns: 1 means the slave acknowledges the byte
0 02 1 a0 5c 1 1
0 03 0 a1 3e 1 0
1 02 1 72 81 0 1
0 05 1 ff 00 1 1
1 03 0 48 c3 0 0
2 02 1 90 7e 1 1
0 0a 0 36 a5 1 0
2 03 1 01 fe 0 0
1 04 1 c4 19 1 1
0 04 0 5a 96 1 1

// ==== verilog/twi_bit_rate.sv ====
/*
 * SCL half-period generator. Pulses tick once every bit_div+1 cycles
 * while the interface is enabled.
 */
`timescale 1ns/10ps
`include "twi_defs.svh"

module twi_bit_rate (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    twen,
    input  logic [`TWI_DIV_W-1:0]   bit_div,
    output logic                    tick
);

    logic [`TWI_DIV_W-1:0] count;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (!twen) begin
            count <= '0;                // Restart from zero on enable
            tick  <= 1'b0;
        end else if (count >= bit_div) begin
            // Greater-or-equal covers a divider lowered mid-count
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// ==== verilog/twi_defs.svh ====
/*
 * TWI master widths, register map, status codes and reset values.
 * Status codes are the 5-bit TWS field (TWSR bits 7..3).
 */
`ifndef TWI_DEFS_SVH
`define TWI_DEFS_SVH

`define TWI_DATA_W          8
`define TWI_ADDR_W          2
`define TWI_DIV_W           16
`define TWI_ST_W            5
`define TWI_BITS_PER_BYTE   8

// I/O register map
`define TWI_ADDR_TWBR       2'd0
`define TWI_ADDR_TWSR       2'd1
`define TWI_ADDR_TWDR       2'd2
`define TWI_ADDR_TWCR       2'd3

`define TWI_ST_START        5'h01   // 0x08
`define TWI_ST_SLA_ACK      5'h03   // 0x18
`define TWI_ST_SLA_NACK     5'h04   // 0x20
`define TWI_ST_DATA_ACK     5'h05   // 0x28
`define TWI_ST_DATA_NACK    5'h06   // 0x30
`define TWI_ST_IDLE         5'h1F   // 0xF8, no state information

`define TWI_TWBR_RST        8'h00
`define TWI_TWCR_RST        8'h00
`define TWI_TWPS_RST        2'b00

`endif

// ==== verilog/twi_master.sv ====
/*
 * TWI bus engine. Runs one START, BYTE or STOP command at a time,
 * steps the open-drain pins on bit-rate ticks and reports a status code.
 */
`timescale 1ns/10ps
`include "twi_defs.svh"

module twi_master import twi_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        twen,
    input  logic        tick,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  twi_cmd_t    cmd,
    output logic        done_valid,
    output twi_done_t   done,
    output twi_pins_t   pins,
    input  logic        sda_in
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_SHIFT,
        S_ACK,
        S_STOP
    } state_e;

    state_e                 state;
    logic [1:0]             phase;      // Tick index within START, STOP or a bit
    logic [3:0]             bit_cnt;
    logic [`TWI_DATA_W-1:0] shift;
    logic                   sda_load;   // Apply sda_val one cycle after SCL falls
    logic                   sda_val;
    logic                   ack;
    logic                   addr_byte;  // Next byte follows a START

    assign cmd_ready = twen && (state == S_IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= S_IDLE;
            phase       <= '0;
            bit_cnt     <= '0;
            sda_load    <= 1'b0;
            sda_val     <= 1'b0;
            ack         <= 1'b0;
            addr_byte   <= 1'b0;
            pins        <= '0;
            done_valid  <= 1'b0;
            done.status <= `TWI_ST_IDLE;
        end else if (!twen) begin
            state      <= S_IDLE;      // Disabled, bus released
            sda_load   <= 1'b0;
            pins       <= '0;
            done_valid <= 1'b0;
        end else begin
            done_valid <= 1'b0;
            sda_load   <= 1'b0;
            if (sda_load)
                pins.sda_drive_low <= sda_val;

            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        phase <= '0;
                        case (cmd.kind)
                            CMD_START: begin
                                state    <= S_START;
                                sda_val  <= 1'b0;   // Let SDA up before the start
                                sda_load <= 1'b1;
                            end
                            CMD_STOP:  state <= S_STOP;
                            default: begin
                                state              <= S_SHIFT;
                                bit_cnt            <= '0;
                                pins.sda_drive_low <= ~cmd.data[`TWI_DATA_W-1];
                                // SCL is already low
                            end
                        endcase
                    end
                end

                S_START: begin
                    if (tick) begin
                        if (phase == 2'd0) begin
                            if (pins.scl_drive_low) begin
                                pins.scl_drive_low <= 1'b0;     // Repeated start setup
                            end else begin
                                pins.sda_drive_low <= 1'b1;     // SDA falls, SCL high
                                phase              <= 2'd1;
                            end
                        end else begin
                            pins.scl_drive_low <= 1'b1;
                            done_valid         <= 1'b1;
                            done.status        <= `TWI_ST_START;
                            addr_byte          <= 1'b1;
                            state              <= S_IDLE;
                        end
                    end
                end

                S_SHIFT: begin
                    if (tick) begin
                        if (phase == 2'd0) begin
                            pins.scl_drive_low <= 1'b0;         // Slave samples here
                            phase              <= 2'd1;
                        end else begin
                            pins.scl_drive_low <= 1'b1;
                            phase              <= 2'd0;
                            sda_load           <= 1'b1;
                            if (bit_cnt == 4'(`TWI_BITS_PER_BYTE - 1)) begin
                                sda_val <= 1'b0;                // Release for ACK
                                state   <= S_ACK;
                            end else begin
                                sda_val <= ~shift[`TWI_DATA_W-2];
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end

                S_ACK: begin
                    if (tick) begin
                        if (phase == 2'd0) begin
                            pins.scl_drive_low <= 1'b0;
                            ack                <= ~sda_in;      // Low SDA means ACK
                            phase              <= 2'd1;
                        end else begin
                            pins.scl_drive_low <= 1'b1;         // Hold SCL until next cmd
                            done_valid         <= 1'b1;
                            addr_byte          <= 1'b0;
                            state              <= S_IDLE;
                            if (addr_byte)
                                done.status <= ack ? `TWI_ST_SLA_ACK : `TWI_ST_SLA_NACK;
                            else
                                done.status <= ack ? `TWI_ST_DATA_ACK : `TWI_ST_DATA_NACK;
                        end
                    end
                end

                S_STOP: begin
                    if (tick) begin
                        case (phase)
                            2'd0: begin
                                pins.scl_drive_low <= 1'b1;
                                sda_val            <= 1'b1;     // SDA low behind SCL
                                sda_load           <= 1'b1;
                                phase              <= 2'd1;
                            end
                            2'd1: begin
                                pins.scl_drive_low <= 1'b0;
                                phase              <= 2'd2;
                            end
                            default: begin
                                pins.sda_drive_low <= 1'b0;     // SDA rises, SCL high
                                done_valid         <= 1'b1;
                                done.status        <= `TWI_ST_IDLE;
                                state              <= S_IDLE;
                            end
                        endcase
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    // Payload load for a new byte
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready && cmd.kind == CMD_BYTE)
            shift <= cmd.data;
        else if (state == S_SHIFT && tick && phase == 2'd1)
            shift <= shift << 1;
    end

endmodule

// ==== verilog/twi_pkg.sv ====
/*
 * Shared types of the TWI master: command and completion records,
 * open-drain pin enables and the CPU write word.
 */
`include "twi_defs.svh"

package twi_pkg;

    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_BYTE  = 2'd2
    } twi_cmd_kind_e;

    typedef struct packed {
        twi_cmd_kind_e              kind;
        logic [`TWI_DATA_W-1:0]     data;   // TWDR snapshot for BYTE
    } twi_cmd_t;

    typedef struct packed {
        logic [`TWI_ST_W-1:0]       status;
    } twi_done_t;

    typedef struct packed {
        logic scl_drive_low;
        logic sda_drive_low;
    } twi_pins_t;

    // TWCR bit layout, MSB first
    typedef struct packed {
        logic twint;
        logic twea;
        logic twsta;
        logic twsto;
        logic twwc;
        logic twen;
        logic rsvd;
        logic twie;
    } twi_twcr_t;

    typedef union packed {
        logic [`TWI_DATA_W-1:0]     raw;
        twi_twcr_t                  ctl;
    } twi_wdata_u;

endpackage

// ==== verilog/twi_regs.sv ====
/*
 * TWI register block: TWBR, TWSR, TWDR and TWCR as seen by the CPU.
 * Issues bus commands on TWCR writes and collects completions.
 */
`timescale 1ns/10ps
`include "twi_defs.svh"

module twi_regs import twi_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [`TWI_ADDR_W-1:0]  io_addr,
    input  twi_wdata_u              io_wdata,
    input  logic                    io_write,
    input  logic                    io_read,
    output logic [`TWI_DATA_W-1:0]  io_rdata,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    output twi_cmd_t                cmd,
    input  logic                    done_valid,
    input  twi_done_t               done,
    output logic                    twen,
    output logic [`TWI_DIV_W-1:0]   bit_div,
    output logic                    twi_interrupt
);

    logic [`TWI_DATA_W-1:0] twbr;
    logic [1:0]             twps;       // Prescaler, the only writable TWSR bits
    logic [`TWI_ST_W-1:0]   tws;
    logic [`TWI_DATA_W-1:0] twdr;
    twi_wdata_u             twcr;       // twea, twwc and rsvd stay zero
    logic                   twcr_wr;
    logic                   issue;

    assign twcr_wr = io_write && (io_addr == `TWI_ADDR_TWCR);
    assign issue   = twcr_wr && io_wdata.ctl.twint && io_wdata.ctl.twen;

    // div = TWBR * 4^TWPS
    assign bit_div = {{(`TWI_DIV_W - `TWI_DATA_W){1'b0}}, twbr} << {twps, 1'b0};

    assign twen          = twcr.ctl.twen;
    assign twi_interrupt = twcr.ctl.twint && twcr.ctl.twie;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            twbr      <= `TWI_TWBR_RST;
            twps      <= `TWI_TWPS_RST;
            tws       <= `TWI_ST_IDLE;
            twcr.raw  <= `TWI_TWCR_RST;
            cmd_valid <= 1'b0;
        end else begin
            if (io_write && io_addr == `TWI_ADDR_TWBR)
                twbr <= io_wdata.raw;
            if (io_write && io_addr == `TWI_ADDR_TWSR)
                twps <= io_wdata.raw[1:0];

            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;

            if (twcr_wr) begin
                twcr.ctl.twsta <= io_wdata.ctl.twsta;
                twcr.ctl.twsto <= io_wdata.ctl.twsto;
                twcr.ctl.twen  <= io_wdata.ctl.twen;
                twcr.ctl.twie  <= io_wdata.ctl.twie;
                if (io_wdata.ctl.twint)
                    twcr.ctl.twint <= 1'b0;     // Write one to clear
                if (!io_wdata.ctl.twen)
                    cmd_valid <= 1'b0;          // Disable drops a pending command
            end
            if (issue)
                cmd_valid <= 1'b1;

            // Completion wins over a same-cycle write
            if (done_valid) begin
                tws <= done.status;
                if (done.status == `TWI_ST_IDLE)
                    twcr.ctl.twsto <= 1'b0;     // STOP sent
                else
                    twcr.ctl.twint <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (io_write && io_addr == `TWI_ADDR_TWDR)
            twdr <= io_wdata.raw;
        if (issue) begin
            cmd.data <= twdr;
            if (io_wdata.ctl.twsta)
                cmd.kind <= CMD_START;
            else if (io_wdata.ctl.twsto)
                cmd.kind <= CMD_STOP;
            else
                cmd.kind <= CMD_BYTE;
        end
    end

    always_comb begin
        io_rdata = '0;
        if (io_read) begin
            case (io_addr)
                `TWI_ADDR_TWBR: io_rdata = twbr;
                `TWI_ADDR_TWSR: io_rdata = {tws, 1'b0, twps};
                `TWI_ADDR_TWDR: io_rdata = twdr;
                `TWI_ADDR_TWCR: io_rdata = twcr.raw;
                default:        io_rdata = '0;
            endcase
        end
    end

endmodule

// ==== verilog/twi_top.sv ====
/*
 * TWI master top level. Connects the register block,
 * the bit-rate generator and the bus engine.
 */
`timescale 1ns/10ps
`include "twi_defs.svh"

module twi_top import twi_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [`TWI_ADDR_W-1:0]  io_addr,
    input  twi_wdata_u              io_wdata,
    input  logic                    io_write,
    input  logic                    io_read,
    output logic [`TWI_DATA_W-1:0]  io_rdata,
    input  logic                    sda_in,
    output twi_pins_t               pins,
    output logic                    twi_interrupt
);

    twi_cmd_t               cmd;
    logic                   cmd_valid;
    logic                   cmd_ready;
    twi_done_t              done;
    logic                   done_valid;
    logic                   twen;
    logic [`TWI_DIV_W-1:0]  bit_div;
    logic                   tick;

    twi_regs i_regs (
        .clk           (clk),
        .reset_n       (reset_n),
        .io_addr       (io_addr),
        .io_wdata      (io_wdata),
        .io_write      (io_write),
        .io_read       (io_read),
        .io_rdata      (io_rdata),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd           (cmd),
        .done_valid    (done_valid),
        .done          (done),
        .twen          (twen),
        .bit_div       (bit_div),
        .twi_interrupt (twi_interrupt)
    );

    twi_bit_rate i_bit_rate (
        .clk     (clk),
        .reset_n (reset_n),
        .twen    (twen),
        .bit_div (bit_div),
        .tick    (tick)
    );

    twi_master i_master (
        .clk        (clk),
        .reset_n    (reset_n),
        .twen       (twen),
        .tick       (tick),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .done_valid (done_valid),
        .done       (done),
        .pins       (pins),
        .sda_in     (sda_in)
    );

endmodule
